// ==== verilog/assistPkg.sv ====
//**********************************************************
// Shared widths, stage payloads and default tuning for the
// motor-assist pipeline. Referenced by scoped name only
//**********************************************************

package assistPkg;

	// Signed roll and pitch from the IMU
	// LSB is half a degree
	localparam int angleW = 10;

	// Heart rate and set point in beats per minute
	localparam int rateW = 8;

	// Signed demand and torque command toward current control
	localparam int torqueW = 13;

	// Tilt cutoff of 45 degrees in half-degree counts
	localparam int rollLimitDefault = 90;

	// Torque counts per bpm of heart-rate error
	localparam int hrGainDefault = 4;

	// Pitch contribution is pitch >> pitchShift
	localparam int pitchShiftDefault = 1;

	// Largest rise of the command from one command to the next
	localparam int rampStepDefault = 256;

	// Absolute torque ceiling
	localparam int torqueMaxDefault = 4095;

	// Decode to execute payload
	// Pitch is already clamped to zero or above here
	typedef struct packed {
		logic [rateW-1:0]  heartRate;
		logic [rateW-1:0]  setPoint;
		logic [angleW-1:0] pitch;
		logic              inhibit;
	} decodedT;

	// Execute to result payload
	// Demand is floored at zero by the execute stage
	typedef struct packed {
		logic signed [torqueW-1:0] demand;
		logic                      inhibit;
	} demandT;

endpackage

// ==== verilog/pipeStage.sv ====
//**********************************************************
// Single-entry valid/ready register stage. The payload type
// is set per instance so one stage body serves every hop
//**********************************************************

`timescale 1ns/1ps

module pipeStage #(
	parameter type payloadT = logic
) (
	input  logic    clk,
	input  logic    rstN,

	// Upstream side
	input  logic    inValid,
	input  payloadT inData,
	output logic    inReady,

	// Downstream side
	output logic    outValid,
	output payloadT outData,
	input  logic    outReady
);

	// Holding register and its occupancy
	logic    full;
	payloadT data;

	// Free when empty or when the held item leaves this cycle
	// Combinational so a full chain still moves every cycle
	assign inReady  = !full || outReady;
	assign outValid = full;
	assign outData  = data;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			full <= 1'b0;
			data <= '0;
		end else if (inReady) begin
			// Refill, or empty out when nothing new arrives
			full <= inValid;
			if (inValid) begin
				data <= inData;
			end
		end
	end

endmodule

// ==== verilog/sensorDecode.sv ====
//**********************************************************
// Decode stage. Forms the assist inhibit from tilt, brake and
// cadence and strips negative pitch. Purely combinational
//**********************************************************

`timescale 1ns/1ps

module sensorDecode #(
	// Tilt cutoff magnitude in half-degree counts
	parameter int rollLimit = assistPkg::rollLimitDefault
) (
	// Biometric inputs
	input  logic        [assistPkg::rateW-1:0]  heartRate,
	input  logic        [assistPkg::rateW-1:0]  setPoint,

	// IMU angles
	input  logic signed [assistPkg::angleW-1:0] roll,
	input  logic signed [assistPkg::angleW-1:0] pitch,

	// Rider inputs
	input  logic                                cadence,
	input  logic                                brake,

	// Payload toward the decode register stage
	output assistPkg::decodedT                  decoded
);

	// One extra bit so that the most negative roll still has a
	// positive magnitude
	logic signed [assistPkg::angleW:0] rollWide;
	logic signed [assistPkg::angleW:0] rollMag;

	// Individual inhibit causes
	logic tiltFault;
	logic brakeFault;
	logic idleFault;

	// Pitch after the downhill clamp
	logic [assistPkg::angleW-1:0] pitchPos;

	// Sign extend before taking the magnitude
	assign rollWide = {roll[assistPkg::angleW-1], roll};

	// Absolute roll, leaning left or right counts the same
	assign rollMag = (rollWide < 0) ? -rollWide : rollWide;

	// Past 45 degrees the bike is treated as falling
	assign tiltFault = (rollMag > rollLimit);

	// Braking always cuts assist
	assign brakeFault = brake;

	// No assist unless the rider is pedalling
	assign idleFault = !cadence;

	// Downhill riding earns no assist
	assign pitchPos = pitch[assistPkg::angleW-1] ? '0 : pitch;

	// Pack the payload
	always_comb begin
		decoded.heartRate = heartRate;
		decoded.setPoint  = setPoint;
		decoded.pitch     = pitchPos;

		// Any single cause forbids assist
		decoded.inhibit = tiltFault | brakeFault | idleFault;
	end

endmodule

// ==== verilog/assistCalc.sv ====
//**********************************************************
// Execute stage. Turns heart-rate error and hill pitch into
// a non-negative assist demand. Purely combinational
//**********************************************************

`timescale 1ns/1ps

module assistCalc #(
	// Torque counts per bpm of error
	parameter int hrGain     = assistPkg::hrGainDefault,
	// Pitch is divided by 2**pitchShift
	parameter int pitchShift = assistPkg::pitchShiftDefault
) (
	// Decoded sample from the decode register stage
	input  assistPkg::decodedT decoded,

	// Demand toward the execute register stage
	output assistPkg::demandT  demand
);

	// Wide working width so no gain setting can wrap the sum
	localparam int calcW = 32;

	// Largest positive value the demand field can carry
	localparam int demandMax = 2 ** (assistPkg::torqueW - 1) - 1;

	// Heart rate minus set point, one bit wider and signed
	logic signed [assistPkg::rateW:0] hrErr;

	// Scaled terms and their sum
	logic signed [calcW-1:0] hrTerm;
	logic signed [calcW-1:0] pitchTerm;
	logic signed [calcW-1:0] sum;

	// Demand after floor and saturation
	logic signed [assistPkg::torqueW-1:0] demandSat;

	// Both rates are unsigned bpm, zero extend before subtracting
	assign hrErr = signed'({1'b0, decoded.heartRate}) - signed'({1'b0, decoded.setPoint});

	// Error times gain
	// Sign extended first so a negative error stays negative
	assign hrTerm = calcW'(hrErr) * hrGain;

	// Pitch is never negative here, a logical shift is enough
	assign pitchTerm = calcW'(decoded.pitch >> pitchShift);

	// Combined assist request
	assign sum = hrTerm + pitchTerm;

	// Rider well below set point gives no assist at all
	always_comb begin
		if (sum < 0) begin
			demandSat = '0;
		end else if (sum > demandMax) begin
			// Keep the value inside the signed demand field
			demandSat = demandMax[assistPkg::torqueW-1:0];
		end else begin
			demandSat = sum[assistPkg::torqueW-1:0];
		end
	end

	// Pack the payload
	always_comb begin
		demand.demand  = demandSat;

		// Inhibit is only carried, the result stage acts on it
		demand.inhibit = decoded.inhibit;
	end

endmodule

// ==== verilog/torqueLimiter.sv ====
//**********************************************************
// Result stage. Applies the inhibit cutoff, the per-command
// ramp limit and the ceiling, and owns the command register
//**********************************************************

`timescale 1ns/1ps

module torqueLimiter #(
	// Largest rise from one command to the next
	parameter int rampStep  = assistPkg::rampStepDefault,
	// Absolute torque ceiling
	parameter int torqueMax = assistPkg::torqueMaxDefault
) (
	input  logic                                 clk,
	input  logic                                 rstN,

	// From the execute register stage
	input  logic                                 inValid,
	input  assistPkg::demandT                    demand,
	output logic                                 inReady,

	// Toward the current-control loop
	output logic                                 cmdValid,
	output logic signed [assistPkg::torqueW-1:0] torqueCmd,
	input  logic                                 cmdReady
);

	// Working width for the comparisons
	localparam int calcW = 32;

	// Accepting an item this cycle
	logic load;

	// Candidates for the new command
	logic signed [calcW-1:0] demandWide;
	logic signed [calcW-1:0] rampCeil;
	logic signed [calcW-1:0] limited;

	// New command value, narrowed to the output width
	logic signed [assistPkg::torqueW-1:0] nextCmd;

	// Free when empty or when the held command leaves now
	assign inReady = !cmdValid || cmdReady;
	assign load    = inValid && inReady;

	// Demand is non-negative, sign extension keeps it as is
	assign demandWide = calcW'(demand.demand);

	// The last command doubles as the ramp state
	assign rampCeil = calcW'(torqueCmd) + rampStep;

	// Smallest of demand, ramp ceiling and torque ceiling
	always_comb begin
		limited = demandWide;
		if (rampCeil < limited) begin
			limited = rampCeil;
		end
		if (torqueMax < limited) begin
			limited = torqueMax;
		end

		// Inhibit overrides everything and drops the ramp to zero
		if (demand.inhibit) begin
			limited = '0;
		end
	end

	// Fits the output width once capped by torqueMax
	assign nextCmd = limited[assistPkg::torqueW-1:0];

	// Output register
	// Command is held under back-pressure and kept after it leaves
	// so the next item ramps from it
	always_ff @(posedge clk) begin
		if (!rstN) begin
			cmdValid  <= 1'b0;
			torqueCmd <= '0;
		end else if (load) begin
			cmdValid  <= 1'b1;
			torqueCmd <= nextCmd;
		end else if (cmdReady) begin
			// Command taken, nothing new behind it
			cmdValid <= 1'b0;
		end
	end

endmodule

// ==== verilog/motorAssist.sv ====
//**********************************************************
// Motor-assist path top level. Chains decode, register,
// execute, register and result into one torque command
//**********************************************************

`timescale 1ns/1ps

module motorAssist #(
	// Decode tuning
	parameter int rollLimit  = assistPkg::rollLimitDefault,
	// Execute tuning
	parameter int hrGain     = assistPkg::hrGainDefault,
	parameter int pitchShift = assistPkg::pitchShiftDefault,
	// Result tuning
	parameter int rampStep   = assistPkg::rampStepDefault,
	parameter int torqueMax  = assistPkg::torqueMaxDefault
) (
	input  logic                                 clk,
	input  logic                                 rstN,

	// Sample handshake
	input  logic                                 sampleValid,
	output logic                                 sampleReady,

	// Biometric inputs
	input  logic        [assistPkg::rateW-1:0]   heartRate,
	input  logic        [assistPkg::rateW-1:0]   setPoint,

	// Resolved IMU angles
	input  logic signed [assistPkg::angleW-1:0]  roll,
	input  logic signed [assistPkg::angleW-1:0]  pitch,

	// Rider inputs
	input  logic                                 cadence,
	input  logic                                 brake,

	// Command toward current control
	output logic                                 cmdValid,
	output logic signed [assistPkg::torqueW-1:0] torqueCmd,
	input  logic                                 cmdReady
);

	// Decode output and its registered copy
	assistPkg::decodedT decodedComb;
	assistPkg::decodedT decodedReg;
	logic               decValid;
	logic               decReady;

	// Execute output and its registered copy
	assistPkg::demandT  demandComb;
	assistPkg::demandT  demandReg;
	logic               calcValid;
	logic               calcReady;

	// Decode is combinational straight off the sample ports
	sensorDecode #(
		.rollLimit (rollLimit)
	) u_decode (
		.heartRate (heartRate),
		.setPoint  (setPoint),
		.roll      (roll),
		.pitch     (pitch),
		.cadence   (cadence),
		.brake     (brake),
		.decoded   (decodedComb)
	);

	// First register, sample handshake lands here
	pipeStage #(
		.payloadT (assistPkg::decodedT)
	) u_decStage (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (sampleValid),
		.inData   (decodedComb),
		.inReady  (sampleReady),
		.outValid (decValid),
		.outData  (decodedReg),
		.outReady (decReady)
	);

	// Heart-rate and pitch demand
	assistCalc #(
		.hrGain     (hrGain),
		.pitchShift (pitchShift)
	) u_calc (
		.decoded (decodedReg),
		.demand  (demandComb)
	);

	// Second register
	pipeStage #(
		.payloadT (assistPkg::demandT)
	) u_calcStage (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (decValid),
		.inData   (demandComb),
		.inReady  (decReady),
		.outValid (calcValid),
		.outData  (demandReg),
		.outReady (calcReady)
	);

	// Third register with the limits
	// A sample taken at edge N leaves at edge N+3 with cmdReady high
	torqueLimiter #(
		.rampStep  (rampStep),
		.torqueMax (torqueMax)
	) u_limit (
		.clk       (clk),
		.rstN      (rstN),
		.inValid   (calcValid),
		.demand    (demandReg),
		.inReady   (calcReady),
		.cmdValid  (cmdValid),
		.torqueCmd (torqueCmd),
		.cmdReady  (cmdReady)
	);

endmodule

// ==== tb/motorAssist_sva.sv ====
//**********************************************************
// Handshake and output-safety assertions, bound to the
// motor-assist top level
//**********************************************************

`timescale 1ns/1ps

module motorAssistSva #(
	parameter int torqueMax = assistPkg::torqueMaxDefault
) (
	input logic                                 clk,
	input logic                                 rstN,
	input logic                                 cmdValid,
	input logic                                 cmdReady,
	input logic signed [assistPkg::torqueW-1:0] torqueCmd
);

	// A stalled command must stay put until it is taken
	holdCmd: assert property (@(posedge clk) disable iff (!rstN)
		(cmdValid && !cmdReady) |=> (cmdValid && $stable(torqueCmd)))
		else $error("torqueCmd changed or was dropped while stalled");

	// Output never leaves the range from zero up to the ceiling
	cmdRange: assert property (@(posedge clk) disable iff (!rstN)
		(torqueCmd >= 0) && (torqueCmd <= torqueMax))
		else $error("torqueCmd %0d outside 0..%0d", torqueCmd, torqueMax);

	// Reset clears the command valid
	resetIdle: assert property (@(posedge clk) !rstN |=> !cmdValid)
		else $error("cmdValid high during reset");

endmodule

// Attach to every instance of the top level
bind motorAssist motorAssistSva #(
	.torqueMax (torqueMax)
) u_sva (
	.clk       (clk),
	.rstN      (rstN),
	.cmdValid  (cmdValid),
	.cmdReady  (cmdReady),
	.torqueCmd (torqueCmd)
);

// ==== tb/motorAssistTb.sv ====
//**********************************************************
// Table-driven testbench for the motor-assist pipeline with
// a reference model, random cmdReady stalls and a summary
//**********************************************************

`timescale 1ns/1ps

module motorAssistTb;

	localparam int numRows     = 24;
	localparam int numGroups   = 5;
	localparam int resetCycles = 16;
	// Per row: three stages plus up to eight stall cycles
	localparam int cycleLimit  = numRows * (3 + 8) + resetCycles + 50;

	// Tuning the DUT runs with
	localparam int rollLimit  = assistPkg::rollLimitDefault;
	localparam int hrGain     = assistPkg::hrGainDefault;
	localparam int pitchShift = assistPkg::pitchShiftDefault;
	localparam int rampStep   = assistPkg::rampStepDefault;
	localparam int torqueMax  = assistPkg::torqueMaxDefault;

	logic                                 clk;
	logic                                 rstN;
	logic                                 sampleValid;
	logic                                 sampleReady;
	logic        [assistPkg::rateW-1:0]   heartRate;
	logic        [assistPkg::rateW-1:0]   setPoint;
	logic signed [assistPkg::angleW-1:0]  roll;
	logic signed [assistPkg::angleW-1:0]  pitch;
	logic                                 cadence;
	logic                                 brake;
	logic                                 cmdValid;
	logic signed [assistPkg::torqueW-1:0] torqueCmd;
	logic                                 cmdReady;

	// Stimulus table, one entry per sample
	int tGroup [numRows];
	int tHr    [numRows];
	int tSp    [numRows];
	int tRoll  [numRows];
	int tPitch [numRows];
	bit tCad   [numRows];
	bit tBrake [numRows];
	int tExp   [numRows];

	string groupName [numGroups];

	// Random stall source
	integer      seed;
	logic [31:0] rnd;
	bit          stallEn;

	// Checker state
	int expIdx;
	int checks;
	int errors;
	int groupStartErr;
	int groupRows;

	// Latency and timeout bookkeeping
	int cycle;
	int firstAccept;
	bit latencyDone;

	motorAssist u_dut (
		.clk         (clk),
		.rstN        (rstN),
		.sampleValid (sampleValid),
		.sampleReady (sampleReady),
		.heartRate   (heartRate),
		.setPoint    (setPoint),
		.roll        (roll),
		.pitch       (pitch),
		.cadence     (cadence),
		.brake       (brake),
		.cmdValid    (cmdValid),
		.torqueCmd   (torqueCmd),
		.cmdReady    (cmdReady)
	);

	// 100 ns period
	always #50 clk = ~clk;

	// Any single condition forbids assist
	function automatic bit isInhibited(int r, bit cad, bit brk);
		int mag;
		mag = (r < 0) ? -r : r;
		return (mag > rollLimit) || brk || !cad;
	endfunction

	// Gain times heart-rate error plus scaled uphill pitch, floored at zero
	function automatic int assistDemand(int hr, int sp, int p);
		int d;
		if (p < 0) begin
			p = 0;
		end
		d = (hr - sp) * hrGain + p / (2 ** pitchShift);
		return (d < 0) ? 0 : d;
	endfunction

	// Smallest of demand, previous plus step and ceiling
	function automatic int limitCmd(int d, int prev);
		int c;
		c = d;
		if (prev + rampStep < c) begin
			c = prev + rampStep;
		end
		if (torqueMax < c) begin
			c = torqueMax;
		end
		return c;
	endfunction

	task automatic setRow(input int i, input int g, input int hr, input int sp,
		input int r, input int p, input bit cad, input bit brk);
		tGroup[i] = g;
		tHr[i]    = hr;
		tSp[i]    = sp;
		tRoll[i]  = r;
		tPitch[i] = p;
		tCad[i]   = cad;
		tBrake[i] = brk;
	endtask

	// Walk the table in order with the model's own ramp state
	task automatic buildExpected();
		int ramp;
		ramp = 0;
		for (int i = 0; i < numRows; i++) begin
			if (isInhibited(tRoll[i], tCad[i], tBrake[i])) begin
				ramp = 0;
			end else begin
				ramp = limitCmd(assistDemand(tHr[i], tSp[i], tPitch[i]), ramp);
			end
			tExp[i] = ramp;
		end
	endtask

	initial begin
		groupName[0] = "heart rate";
		groupName[1] = "pitch";
		groupName[2] = "inhibit";
		groupName[3] = "ramp and ceiling";
		groupName[4] = "back-pressure";

		// Level ground, rising heart-rate error
		setRow(0, 0, 130, 120, 0, 0, 1, 0);
		setRow(1, 0, 150, 120, 0, 0, 1, 0);
		setRow(2, 0, 200, 100, 0, 0, 1, 0);
		setRow(3, 0, 200, 100, 0, 0, 1, 0);
		// Uphill, downhill, rider above set point
		setRow(4, 1, 120, 120, 0, 60, 1, 0);
		setRow(5, 1, 130, 120, 0, 100, 1, 0);
		setRow(6, 1, 130, 120, 0, -80, 1, 0);
		setRow(7, 1, 110, 120, 0, 10, 1, 0);
		// Tilt either side, brake, no cadence, edge of the tilt window
		setRow(8, 2, 160, 120, 0, 0, 1, 0);
		setRow(9, 2, 160, 120, 91, 0, 1, 0);
		setRow(10, 2, 180, 100, -91, 0, 1, 0);
		setRow(11, 2, 180, 100, 90, 0, 1, 0);
		setRow(12, 2, 180, 100, 0, 0, 1, 1);
		setRow(13, 2, 180, 100, 0, 0, 0, 0);
		setRow(14, 2, 180, 100, -90, 0, 1, 0);
		// Largest demand ramps up, then a sudden drop
		setRow(15, 3, 255, 0, 0, 511, 1, 0);
		setRow(16, 3, 255, 0, 0, 511, 1, 0);
		setRow(17, 3, 255, 0, 0, 511, 1, 0);
		setRow(18, 3, 255, 0, 0, 511, 1, 0);
		setRow(19, 3, 150, 130, 0, 0, 1, 0);
		// Mixed rows under random stalls
		setRow(20, 4, 140, 120, 0, 40, 1, 0);
		setRow(21, 4, 200, 120, 0, 0, 1, 0);
		setRow(22, 4, 200, 120, 200, 0, 1, 0);
		setRow(23, 4, 170, 120, 0, -5, 1, 0);
		buildExpected();
	end

	// cmdReady stays high until the stall group starts
	always @(posedge clk) begin
		if (stallEn) begin
			rnd = $random(seed);
			cmdReady <= rnd[0];
		end else begin
			cmdReady <= 1'b1;
		end
	end

	// Output checker, expected values in table order
	always @(posedge clk) begin
		if (rstN && cmdValid && cmdReady) begin
			if (expIdx >= numRows) begin
				$display("Extra command %0d at %0t after every row was checked",
					torqueCmd, $time);
				errors++;
			end else begin
				checks++;
				groupRows++;
				assert (torqueCmd == tExp[expIdx]) else begin
					$display("error t=%0t torqueCmd expected %0d actual %0d",
						$time, tExp[expIdx], torqueCmd);
					errors++;
				end
				// Last row of its group
				if (expIdx == numRows - 1 || tGroup[expIdx + 1] != tGroup[expIdx]) begin
					$display("Group %s: %0d rows, %0d errors", groupName[tGroup[expIdx]],
						groupRows, errors - groupStartErr);
					groupStartErr = errors;
					groupRows     = 0;
				end
				expIdx++;
			end
		end
	end

	// Cycle count, first-command latency and timeout
	always @(posedge clk) begin
		if (rstN && firstAccept < 0 && sampleValid && sampleReady) begin
			firstAccept = cycle;
		end
		// cmdValid rises after edge N+2 and the command is taken at edge N+3
		if (rstN && firstAccept >= 0 && !latencyDone && cmdValid) begin
			latencyDone = 1'b1;
			checks++;
			assert (cycle - firstAccept == 3) else begin
				$display("error t=%0t cmdValid latency expected 3 actual %0d",
					$time, cycle - firstAccept);
				errors++;
			end
			$display("Group latency: first command after %0d cycles",
				cycle - firstAccept);
		end
		if (cycle > cycleLimit) begin
			$display("Timeout: only %0d of %0d commands arrived within %0d cycles",
				expIdx, numRows, cycleLimit);
			$display("Regression failed");
			$finish;
		end
		cycle++;
	end

	// Reset, then drive every row and wait for its handshake
	initial begin
		clk           = 1'b0;
		rstN          = 1'b0;
		sampleValid   = 1'b0;
		heartRate     = '0;
		setPoint      = '0;
		roll          = '0;
		pitch         = '0;
		cadence       = 1'b0;
		brake         = 1'b0;
		cmdReady      = 1'b1;
		seed          = 32'h6095;
		stallEn       = 1'b0;
		expIdx        = 0;
		checks        = 0;
		errors        = 0;
		groupStartErr = 0;
		groupRows     = 0;
		cycle         = 0;
		firstAccept   = -1;
		latencyDone   = 1'b0;

		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
		@(posedge clk);

		for (int i = 0; i < numRows; i++) begin
			if (tGroup[i] == 4) begin
				stallEn <= 1'b1;
			end
			sampleValid <= 1'b1;
			heartRate   <= tHr[i];
			setPoint    <= tSp[i];
			roll        <= tRoll[i];
			pitch       <= tPitch[i];
			cadence     <= tCad[i];
			brake       <= tBrake[i];
			@(posedge clk);
			// Ready is read before this edge's register updates
			while (!sampleReady) @(posedge clk);
		end
		sampleValid <= 1'b0;

		wait (expIdx == numRows);
		// Give any duplicate command time to show up
		repeat (8) @(posedge clk);

		if (!latencyDone) begin
			$display("The first command never appeared, latency was not measured");
			errors++;
		end
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== motorAssist.f ====
verilog/assistPkg.sv
verilog/pipeStage.sv
verilog/sensorDecode.sv
verilog/assistCalc.sv
verilog/torqueLimiter.sv
verilog/motorAssist.sv
tb/motorAssist_sva.sv
tb/motorAssistTb.sv
